// File: icache_cfg.svh
/*
 * instruction cache configuration
 * geometry of the two-way cache and the address split derived from it
 */

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// byte address width
`define ICACHE_ADDR_W      32
// words per line (2, 4 or 8)
`define ICACHE_LINE_WORDS  4
// sets (any power of two)
`define ICACHE_SETS        16
// fixed associativity with one plru bit per set
`define ICACHE_WAYS        2

// derived address split
`define ICACHE_OFS_W       ($clog2(`ICACHE_LINE_WORDS) + 2)
`define ICACHE_IDX_W       ($clog2(`ICACHE_SETS))
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W)

`endif

// File: icache_pkg.sv
/*
 * instruction cache types
 * address fields, line layout and the two state machine encodings
 */

`include "icache_cfg.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [31:0]               word_t;
  typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
  typedef logic [`ICACHE_IDX_W-1:0]  idx_t;
  typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;

  // 0 index-invalidate, 1 hit-invalidate
  typedef logic [0:0] cacop_mode_t;

  // core miss handling
  typedef enum logic [1:0] {
    M_IDLE,
    M_MISS,
    M_REFILL,
    M_DONE
  } miss_state_t;

  // per-word four-phase bus exchange
  typedef enum logic [1:0] {
    R_IDLE,
    R_REQ,
    R_WAIT_ACK_LOW,
    R_FINISH
  } refill_state_t;

endpackage

// File: sdp_ram.sv
/*
 * simple dual-port synchronous RAM
 * one write port, one registered read port, write-first on collision
 */

`timescale 1ns/100ps

module sdp_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    // same-cycle write is forwarded to the read register
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// File: icache_refill.sv
/*
 * line refill engine
 * fetches one cache line word by word, each word through a four-phase
 * req/ack exchange, and holds the assembled line until the next start
 */

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_refill (
  input  logic              clk,
  input  logic              rst_n,
  // from the core
  input  logic              refill_start_i,
  input  icache_pkg::addr_t refill_addr_i,
  output logic              refill_done_o,
  output icache_pkg::line_t refill_line_o,
  // word bus
  output logic              mem_req_o,
  output icache_pkg::addr_t mem_addr_o,
  input  logic              mem_ack_i,
  input  icache_pkg::word_t mem_rdata_i
);

  import icache_pkg::*;

  localparam int WSEL_W = `ICACHE_OFS_W - 2;
  localparam logic [WSEL_W-1:0] LAST_WORD = WSEL_W'(`ICACHE_LINE_WORDS - 1);

  refill_state_t     state;
  logic [WSEL_W-1:0] cnt;
  addr_t             line_addr;
  line_t             line_buf;

  // ==========================
  // handshake FSM
  // ==========================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= R_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          if (refill_start_i) begin
            state <= R_REQ;
            cnt   <= '0;
          end
        end
        R_REQ: begin
          // data is valid together with ack
          if (mem_ack_i) begin
            state <= R_WAIT_ACK_LOW;
          end
        end
        R_WAIT_ACK_LOW: begin
          if (!mem_ack_i) begin
            if (cnt == LAST_WORD) begin
              state <= R_FINISH;
            end else begin
              cnt   <= cnt + 1'b1;
              state <= R_REQ;
            end
          end
        end
        R_FINISH: begin
          state <= R_IDLE;
        end
        default: begin
          state <= R_IDLE;
        end
      endcase
    end
  end

  // address latch and line assembly
  always_ff @(posedge clk) begin
    if ((state == R_IDLE) && refill_start_i) begin
      line_addr <= refill_addr_i;
    end
    if ((state == R_REQ) && mem_ack_i) begin
      line_buf[cnt] <= mem_rdata_i;
    end
  end

  assign mem_req_o     = (state == R_REQ);
  assign mem_addr_o    = {line_addr[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], cnt, 2'b00};
  // one-cycle pulse after the last ack has dropped
  assign refill_done_o = (state == R_FINISH);
  assign refill_line_o = line_buf;

endmodule

// File: icache_core.sv
/*
 * instruction cache core
 * two-stage lookup with tag match, plru replacement and valid bits,
 * maintenance invalidates and the miss state machine that drives
 * the refill engine and writes the refilled line into the victim way
 */

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_core (
  input  logic                                      clk,
  input  logic                                      rst_n,
  // fetch
  input  logic                                      fetch_req_i,
  input  icache_pkg::addr_t                         fetch_addr_i,
  output logic                                      fetch_ready_o,
  // response
  output logic                                      rsp_valid_o,
  output icache_pkg::addr_t                         rsp_addr_o,
  output icache_pkg::word_t                         rsp_instr_o,
  output logic                                      rsp_excp_o,
  input  logic                                      rsp_ready_i,
  // maintenance
  input  logic                                      cacop_req_i,
  input  icache_pkg::cacop_mode_t                   cacop_mode_i,
  input  icache_pkg::addr_t                         cacop_addr_i,
  output logic                                      cacop_ready_o,
  output logic                                      cacop_done_o,
  input  logic                                      flush_i,
  // refill engine
  output logic                                      refill_start_o,
  output icache_pkg::addr_t                         refill_addr_o,
  input  logic                                      refill_done_i,
  input  icache_pkg::line_t                         refill_line_i,
  // data rams
  output logic [`ICACHE_WAYS-1:0]                   data_we_o,
  output icache_pkg::idx_t                          data_widx_o,
  output icache_pkg::line_t                         data_wline_o,
  output icache_pkg::idx_t                          data_ridx_o,
  input  icache_pkg::line_t [`ICACHE_WAYS-1:0]      data_rline_i,
  // tag rams
  output logic [`ICACHE_WAYS-1:0]                   tag_we_o,
  output icache_pkg::idx_t                          tag_widx_o,
  output icache_pkg::tag_t                          tag_wdata_o,
  output icache_pkg::idx_t                          tag_ridx_o,
  input  icache_pkg::tag_t [`ICACHE_WAYS-1:0]       tag_rdata_i
);

  import icache_pkg::*;

  localparam int WSEL_W = `ICACHE_OFS_W - 2;

  logic                 init_q;
  logic                 s0_ready;
  logic                 s1_ready;
  addr_t                s0_addr;
  idx_t                 s0_idx;
  logic                 s0_misalign;

  logic                 s1_fetch_en;
  logic                 s1_cacop_en;
  logic                 s1_misalign;
  cacop_mode_t          s1_cacop_mode;
  addr_t                s1_addr;
  idx_t                 s1_idx;
  tag_t                 s1_tag;
  logic [WSEL_W-1:0]    s1_wsel;

  logic [`ICACHE_WAYS-1:0] hit_way;
  logic                 hit;
  logic                 hit_idx;
  logic                 victim;
  logic                 hit_fire;
  logic                 refill_write;

  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;
  logic [`ICACHE_SETS-1:0] plru_q;
  miss_state_t          miss_state;

  // ==============================
  // stage 0
  // ==============================

  // first cycle after reset is spent with stage 1 empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_q <= 1'b0;
    end else begin
      init_q <= 1'b1;
    end
  end

  assign s0_ready      = s1_ready & init_q & ~flush_i;
  // maintenance has priority over fetch
  assign cacop_ready_o = s0_ready;
  assign fetch_ready_o = s0_ready & ~cacop_req_i;

  assign s0_addr     = cacop_req_i ? cacop_addr_i : fetch_addr_i;
  assign s0_idx      = s0_addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign s0_misalign = ~cacop_req_i & (fetch_addr_i[1:0] != 2'b00);

  // re-read the held set while stage 1 stalls
  assign data_ridx_o = s1_ready ? s0_idx : s1_idx;
  assign tag_ridx_o  = s1_ready ? s0_idx : s1_idx;

  // ==============================
  // stage 1
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_fetch_en <= 1'b0;
      s1_cacop_en <= 1'b0;
    end else if (flush_i) begin
      s1_fetch_en <= 1'b0;
      s1_cacop_en <= 1'b0;
    end else if (s1_ready) begin
      s1_fetch_en <= fetch_req_i & fetch_ready_o;
      s1_cacop_en <= cacop_req_i & cacop_ready_o;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_addr       <= s0_addr;
      s1_misalign   <= s0_misalign;
      s1_cacop_mode <= cacop_mode_i;
    end
  end

  assign s1_idx  = s1_addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign s1_tag  = s1_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign s1_wsel = s1_addr[`ICACHE_OFS_W-1:2];

  // tag match against current valid bits
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_way[w] = valid_q[w][s1_idx] && (tag_rdata_i[w] == s1_tag);
    end
  end

  assign hit     = |hit_way;
  // two ways, so the way number is the upper match bit
  assign hit_idx = hit_way[1];
  assign victim  = plru_q[s1_idx];

  always_comb begin
    case (miss_state)
      M_IDLE:   rsp_valid_o = s1_fetch_en & (s1_misalign | hit);
      M_REFILL: rsp_valid_o = s1_fetch_en & refill_done_i;
      M_DONE:   rsp_valid_o = s1_fetch_en;
      default:  rsp_valid_o = 1'b0;
    endcase
  end

  assign rsp_addr_o  = s1_addr;
  assign rsp_excp_o  = s1_misalign;
  // hits read the data ram, misses read the refill buffer
  assign rsp_instr_o = (miss_state == M_IDLE) ? data_rline_i[hit_idx][s1_wsel]
                                              : refill_line_i[s1_wsel];

  assign cacop_done_o = s1_cacop_en;

  always_comb begin
    if (s1_cacop_en) begin
      s1_ready = 1'b1;
    end else if (s1_fetch_en) begin
      s1_ready = rsp_valid_o & rsp_ready_i;
    end else begin
      // an orphaned refill after a flush must drain first
      s1_ready = (miss_state == M_IDLE);
    end
  end

  // ==============================
  // miss handling
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      miss_state <= M_IDLE;
    end else begin
      case (miss_state)
        M_IDLE: begin
          if (s1_fetch_en && !s1_misalign && !hit && !flush_i) begin
            miss_state <= M_MISS;
          end
        end
        M_MISS: begin
          miss_state <= M_REFILL;
        end
        M_REFILL: begin
          if (refill_done_i) begin
            if (!s1_fetch_en || rsp_ready_i || flush_i) begin
              miss_state <= M_IDLE;
            end else begin
              miss_state <= M_DONE;
            end
          end
        end
        M_DONE: begin
          if (rsp_ready_i || flush_i) begin
            miss_state <= M_IDLE;
          end
        end
        default: begin
          miss_state <= M_IDLE;
        end
      endcase
    end
  end

  assign refill_start_o = (miss_state == M_MISS);
  assign refill_addr_o  = {s1_addr[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};

  // no write when the request was flushed during the refill
  assign refill_write = (miss_state == M_REFILL) & refill_done_i & s1_fetch_en;
  assign hit_fire     = (miss_state == M_IDLE) & s1_fetch_en & ~s1_misalign & hit & rsp_ready_i;

  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      data_we_o[w] = refill_write && (int'(victim) == w);
      tag_we_o[w]  = refill_write && (int'(victim) == w);
    end
  end

  assign data_widx_o  = s1_idx;
  assign data_wline_o = refill_line_i;
  assign tag_widx_o   = s1_idx;
  assign tag_wdata_o  = s1_tag;

  // valid and plru state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      plru_q  <= '0;
    end else begin
      if (refill_write) begin
        valid_q[victim][s1_idx] <= 1'b1;
        plru_q[s1_idx]          <= ~victim;
      end else if (hit_fire) begin
        plru_q[s1_idx] <= ~hit_idx;
      end
      if (s1_cacop_en) begin
        if (s1_cacop_mode == 1'b0) begin
          // index-invalidate, way from address bit 0
          valid_q[s1_addr[0]][s1_idx] <= 1'b0;
        end else if (hit) begin
          valid_q[hit_idx][s1_idx] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: icache_top.sv
/*
 * instruction cache top level
 * connects the lookup core, the refill engine and the tag and data
 * RAMs of both ways
 */

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_req_i,
  input  icache_pkg::addr_t       fetch_addr_i,
  output logic                    fetch_ready_o,
  output logic                    rsp_valid_o,
  output icache_pkg::addr_t       rsp_addr_o,
  output icache_pkg::word_t       rsp_instr_o,
  output logic                    rsp_excp_o,
  input  logic                    rsp_ready_i,
  input  logic                    cacop_req_i,
  input  icache_pkg::cacop_mode_t cacop_mode_i,
  input  icache_pkg::addr_t       cacop_addr_i,
  output logic                    cacop_ready_o,
  output logic                    cacop_done_o,
  input  logic                    flush_i,
  output logic                    mem_req_o,
  output icache_pkg::addr_t       mem_addr_o,
  input  logic                    mem_ack_i,
  input  icache_pkg::word_t       mem_rdata_i
);

  import icache_pkg::*;

  logic                           refill_start;
  addr_t                          refill_addr;
  logic                           refill_done;
  line_t                          refill_line;

  logic [`ICACHE_WAYS-1:0]        data_we;
  idx_t                           data_widx;
  line_t                          data_wline;
  idx_t                           data_ridx;
  line_t [`ICACHE_WAYS-1:0]       data_rline;

  logic [`ICACHE_WAYS-1:0]        tag_we;
  idx_t                           tag_widx;
  tag_t                           tag_wdata;
  idx_t                           tag_ridx;
  tag_t [`ICACHE_WAYS-1:0]        tag_rdata;

  icache_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_addr_o     (rsp_addr_o),
    .rsp_instr_o    (rsp_instr_o),
    .rsp_excp_o     (rsp_excp_o),
    .rsp_ready_i    (rsp_ready_i),
    .cacop_req_i    (cacop_req_i),
    .cacop_mode_i   (cacop_mode_i),
    .cacop_addr_i   (cacop_addr_i),
    .cacop_ready_o  (cacop_ready_o),
    .cacop_done_o   (cacop_done_o),
    .flush_i        (flush_i),
    .refill_start_o (refill_start),
    .refill_addr_o  (refill_addr),
    .refill_done_i  (refill_done),
    .refill_line_i  (refill_line),
    .data_we_o      (data_we),
    .data_widx_o    (data_widx),
    .data_wline_o   (data_wline),
    .data_ridx_o    (data_ridx),
    .data_rline_i   (data_rline),
    .tag_we_o       (tag_we),
    .tag_widx_o     (tag_widx),
    .tag_wdata_o    (tag_wdata),
    .tag_ridx_o     (tag_ridx),
    .tag_rdata_i    (tag_rdata)
  );

  icache_refill u_refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .refill_start_i (refill_start),
    .refill_addr_i  (refill_addr),
    .refill_done_o  (refill_done),
    .refill_line_o  (refill_line),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rdata_i    (mem_rdata_i)
  );

  // ========== way storage ==========
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    sdp_ram #(
      .DEPTH (`ICACHE_SETS),
      .WIDTH ($bits(line_t))
    ) u_data_ram (
      .clk     (clk),
      .we_i    (data_we[w]),
      .waddr_i (data_widx),
      .wdata_i (data_wline),
      .raddr_i (data_ridx),
      .rdata_o (data_rline[w])
    );

    sdp_ram #(
      .DEPTH (`ICACHE_SETS),
      .WIDTH (`ICACHE_TAG_W)
    ) u_tag_ram (
      .clk     (clk),
      .we_i    (tag_we[w]),
      .waddr_i (tag_widx),
      .wdata_i (tag_wdata),
      .raddr_i (tag_ridx),
      .rdata_o (tag_rdata[w])
    );
  end

endmodule

// File: tb_mem_model.sv
/*
 * backing memory model
 * answers each four-phase word request with the complement of the
 * word address after 1 to 3 cycles, counts rising edges of the request
 */

`timescale 1ns/100ps

module tb_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        mem_req_i,
  input  logic [31:0] mem_addr_i,
  output logic        mem_ack_o,
  output logic [31:0] mem_rdata_o,
  output int          req_count_o
);

  logic req_q;

  // request edge counter
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q       <= 1'b0;
      req_count_o <= 0;
    end else begin
      req_q <= mem_req_i;
      if (mem_req_i && !req_q) begin
        req_count_o <= req_count_o + 1;
      end
    end
  end

  // ==============================
  // responder, falling edge
  // ==============================
  initial begin
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req_i) begin
        // one to three cycles before ack
        repeat (1 + ($urandom % 3)) @(negedge clk);
        mem_rdata_o = ~mem_addr_i;
        mem_ack_o   = 1'b1;
        while (mem_req_i) begin
          @(negedge clk);
        end
        mem_ack_o = 1'b0;
      end
    end
  end

endmodule

// File: tb_icache.sv
/*
 * instruction cache testbench
 * drives fetch and maintenance traffic, predicts hits, misses and plru
 * victims with a reference model, and checks every response, the
 * maintenance done pulse and the number of memory requests
 */

`timescale 1ns/100ps

`include "icache_cfg.svh"

module tb_icache;

  import icache_pkg::*;

  localparam int LW           = `ICACHE_LINE_WORDS;
  localparam int SET_STRIDE   = `ICACHE_SETS * LW * 4;
  localparam int SEED         = 97829;
  localparam int STREAM_LEN   = 64;
  localparam int DIRECTED_OPS = 20;
  localparam int TIMEOUT_CYC  = 200 * (STREAM_LEN + DIRECTED_OPS);

  logic        clk;
  logic        rst_n;
  logic        fetch_req_i;
  addr_t       fetch_addr_i;
  logic        fetch_ready_o;
  logic        rsp_valid_o;
  addr_t       rsp_addr_o;
  word_t       rsp_instr_o;
  logic        rsp_excp_o;
  logic        rsp_ready_i;
  logic        cacop_req_i;
  cacop_mode_t cacop_mode_i;
  addr_t       cacop_addr_i;
  logic        cacop_ready_o;
  logic        cacop_done_o;
  logic        flush_i;
  logic        mem_req_o;
  addr_t       mem_addr_o;
  logic        mem_ack_i;
  word_t       mem_rdata_i;
  int          req_count;

  // reference model of valid, tag and plru state
  logic  m_valid [2][`ICACHE_SETS];
  tag_t  m_tag   [2][`ICACHE_SETS];
  logic  m_plru  [`ICACHE_SETS];
  int    exp_reqs;
  addr_t exp_addr_q [$];
  logic  exp_excp_q [$];
  int    rsp_due_q  [$];
  logic  rsp_fast_q [$];
  int    done_due_q [$];

  int    cyc = 0;
  int    errors;
  logic  bp_en;
  logic  stall_q;
  addr_t held_addr;
  word_t held_instr;
  logic  held_excp;

  icache_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_addr_o    (rsp_addr_o),
    .rsp_instr_o   (rsp_instr_o),
    .rsp_excp_o    (rsp_excp_o),
    .rsp_ready_i   (rsp_ready_i),
    .cacop_req_i   (cacop_req_i),
    .cacop_mode_i  (cacop_mode_i),
    .cacop_addr_i  (cacop_addr_i),
    .cacop_ready_o (cacop_ready_o),
    .cacop_done_o  (cacop_done_o),
    .flush_i       (flush_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  tb_mem_model u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_req_i   (mem_req_o),
    .mem_addr_i  (mem_addr_o),
    .mem_ack_o   (mem_ack_i),
    .mem_rdata_o (mem_rdata_i),
    .req_count_o (req_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_failure();
    errors = errors + 1;
    $display("Done: errors found");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
    report_failure();
  endtask

  // ==============================
  // reference model
  // ==============================
  // returns 1 when the response is due the cycle after acceptance
  function automatic logic predict_fetch(input addr_t a);
    idx_t idx;
    tag_t tag;
    logic way;
    logic hit;
    idx = a[`ICACHE_OFS_W +: `ICACHE_IDX_W];
    tag = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    exp_addr_q.push_back(a);
    exp_excp_q.push_back(a[1:0] != 2'b00);
    if (a[1:0] != 2'b00) begin
      return 1'b1;
    end
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (m_valid[w][idx] && (m_tag[w][idx] == tag)) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (hit) begin
      m_plru[idx] = ~way;
      return 1'b1;
    end
    // refill goes to the way the plru bit names
    way              = m_plru[idx];
    m_valid[way][idx] = 1'b1;
    m_tag[way][idx]   = tag;
    m_plru[idx]       = ~way;
    exp_reqs          = exp_reqs + LW;
    return 1'b0;
  endfunction

  function automatic void predict_cacop(input cacop_mode_t mode, input addr_t a);
    idx_t idx;
    tag_t tag;
    idx = a[`ICACHE_OFS_W +: `ICACHE_IDX_W];
    tag = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    if (mode == 1'b0) begin
      m_valid[a[0]][idx] = 1'b0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (m_valid[w][idx] && (m_tag[w][idx] == tag)) begin
          m_valid[w][idx] = 1'b0;
        end
      end
    end
  endfunction

  // ==============================
  // drivers, called on a falling edge
  // ==============================
  task automatic issue_fetch(input addr_t a);
    fetch_req_i  = 1'b1;
    fetch_addr_i = a;
    #0.5;
    while (!fetch_ready_o) begin
      @(negedge clk);
      #0.5;
    end
    // taken on the coming rising edge
    rsp_fast_q.push_back(predict_fetch(a));
    rsp_due_q.push_back(cyc + 1);
    @(negedge clk);
    fetch_req_i = 1'b0;
  endtask

  task automatic issue_cacop(input cacop_mode_t mode, input addr_t a);
    cacop_req_i  = 1'b1;
    cacop_mode_i = mode;
    cacop_addr_i = a;
    #0.5;
    while (!cacop_ready_o) begin
      @(negedge clk);
      #0.5;
    end
    predict_cacop(mode, a);
    done_due_q.push_back(cyc + 1);
    @(negedge clk);
    cacop_req_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_addr_q.size() != 0) begin
      @(negedge clk);
    end
    assert (req_count == exp_reqs)
      else value_error("mem request count", req_count, exp_reqs);
  endtask

  // ==============================
  // response and done checks
  // ==============================
  task automatic check_outputs();
    logic exp_done;
    if (stall_q) begin
      assert (rsp_valid_o) else value_error("rsp_valid_o", rsp_valid_o, 1'b1);
      assert (rsp_addr_o == held_addr) else value_error("rsp_addr_o", rsp_addr_o, held_addr);
      assert (rsp_excp_o == held_excp) else value_error("rsp_excp_o", rsp_excp_o, held_excp);
      assert (held_excp || (rsp_instr_o == held_instr))
        else value_error("rsp_instr_o", rsp_instr_o, held_instr);
    end
    if ((rsp_due_q.size() != 0) && (rsp_due_q[0] == cyc)) begin
      assert (rsp_valid_o == rsp_fast_q[0])
        else value_error("rsp_valid_o", rsp_valid_o, rsp_fast_q[0]);
      void'(rsp_due_q.pop_front());
      void'(rsp_fast_q.pop_front());
    end
    exp_done = (done_due_q.size() != 0) && (done_due_q[0] == cyc);
    assert (cacop_done_o == exp_done) else value_error("cacop_done_o", cacop_done_o, exp_done);
    if (exp_done) begin
      void'(done_due_q.pop_front());
    end
    if (rsp_valid_o && rsp_ready_i) begin
      if (exp_addr_q.size() == 0) begin
        $display("unexpected response at %0t ns with no fetch outstanding", $time);
        report_failure();
      end else begin
        assert (rsp_addr_o == exp_addr_q[0])
          else value_error("rsp_addr_o", rsp_addr_o, exp_addr_q[0]);
        assert (rsp_excp_o == exp_excp_q[0])
          else value_error("rsp_excp_o", rsp_excp_o, exp_excp_q[0]);
        assert (exp_excp_q[0] || (rsp_instr_o == ~exp_addr_q[0]))
          else value_error("rsp_instr_o", rsp_instr_o, ~exp_addr_q[0]);
        void'(exp_addr_q.pop_front());
        void'(exp_excp_q.pop_front());
      end
    end
    stall_q    = rsp_valid_o && !rsp_ready_i;
    held_addr  = rsp_addr_o;
    held_instr = rsp_instr_o;
    held_excp  = rsp_excp_o;
  endtask

  initial begin : monitor
    stall_q = 1'b0;
    forever begin
      @(negedge clk);
      #1;
      if (rst_n) begin
        check_outputs();
      end
    end
  end

  initial begin : backpressure
    void'($urandom(SEED));
    forever begin
      @(negedge clk);
      rsp_ready_i = bp_en ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout after %0d cycles, the cache stopped responding", TIMEOUT_CYC);
    report_failure();
  end

  initial begin : stimulus
    addr_t a;
    int    n;
    rst_n        = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    rsp_ready_i  = 1'b1;
    cacop_req_i  = 1'b0;
    cacop_mode_i = '0;
    cacop_addr_i = '0;
    flush_i      = 1'b0;
    bp_en        = 1'b0;
    exp_reqs     = 0;
    errors       = 0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_plru[s]     = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // cold miss, hit on the same line, misaligned fetch
    issue_fetch(32'h0000_1040);
    drain();
    issue_fetch(32'h0000_1044);
    drain();
    issue_fetch(32'h0000_1046);
    drain();

    // A and B fill set 3, A is touched, then C evicts B
    a = 32'h0000_2030;
    issue_fetch(a);
    issue_fetch(a + SET_STRIDE);
    issue_fetch(a + 4);
    issue_fetch(a + 2 * SET_STRIDE);
    drain();
    n = req_count;
    issue_fetch(a + 8);
    drain();
    assert (req_count == n) else value_error("mem request count", req_count, n);
    issue_fetch(a + SET_STRIDE);
    drain();
    assert (req_count == n + LW) else value_error("mem request count", req_count, n + LW);

    // hit-invalidate forces the next fetch to miss
    a = 32'h0000_3050;
    issue_fetch(a);
    drain();
    issue_cacop(1'b1, a);
    n = req_count;
    issue_fetch(a);
    drain();
    assert (req_count == n + LW) else value_error("mem request count", req_count, n + LW);

    // set 6 starts empty, so E lands in way 0 and F in way 1
    a = 32'h0000_4060;
    issue_fetch(a);
    issue_fetch(a + SET_STRIDE);
    drain();
    issue_cacop(1'b0, a);
    n = req_count;
    issue_fetch(a + SET_STRIDE);
    drain();
    assert (req_count == n) else value_error("mem request count", req_count, n);
    issue_fetch(a);
    drain();
    assert (req_count == n + LW) else value_error("mem request count", req_count, n + LW);

    // hit-invalidate that misses leaves set 4 alone
    issue_cacop(1'b1, 32'h0000_9040);
    n = req_count;
    issue_fetch(32'h0000_1048);
    drain();
    assert (req_count == n) else value_error("mem request count", req_count, n);

    // back-to-back stream under random back-pressure
    bp_en = 1'b1;
    for (int i = 0; i < STREAM_LEN; i++) begin
      a = 32'h0000_8000 + ((i * 13) % 40) * 8;
      if (i % 11 == 5) begin
        a = a + 2;
      end
      issue_fetch(a);
    end
    drain();
    bp_en = 1'b0;
    repeat (2) @(negedge clk);

    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

// File: src.f
+incdir+.
icache_pkg.sv
sdp_ram.sv
icache_refill.sv
icache_core.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f src.f -o tb_icache \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_icache > sim.log 2>&1 || echo "simulation exited with an error status"
cat sim.log
! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
